// ==== spi_bus_pkg.sv ====
package spi_bus_pkg;

    // AXI4-Lite port geometry
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_ADDR_WIDTH = 8;
    localparam int STRB_WIDTH     = AXI_DATA_WIDTH / 8;

    // Word index sits above the byte lane bits of the address
    localparam int WORD_LSB       = $clog2(STRB_WIDTH);
    localparam int WORD_ADDR_BITS = 4;  // 16 words cover the register space

    typedef logic [AXI_DATA_WIDTH-1:0] word_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;

    // Only OKAY is ever returned
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

// ==== spi_regs_pkg.sv ====
package spi_regs_pkg;

    localparam int MEMORY_BYTES = 64;
    localparam int NUM_SLAVES   = 2;

    // Byte offsets in the register space
    localparam int CTRL_BYTE    = 0;
    localparam int SLAVE_BYTE   = 1;
    localparam int DIV_BYTE     = 2;   // Clocks to skip between engine steps
    localparam int TX_BITS_BYTE = 4;   // 16 bits, little endian
    localparam int RX_BITS_BYTE = 8;   // 16 bits, little endian
    localparam int TX_BUF_BYTE  = 16;
    localparam int RX_BUF_BYTE  = 32;
    localparam int BUF_BYTES    = 8;

    // Bit positions inside the control byte
    localparam int CTRL_CPOL  = 0;
    localparam int CTRL_CPHA  = 1;
    localparam int CTRL_START = 2;
    localparam int CTRL_READ  = 4;

    typedef logic [15:0]           bit_count_t;
    typedef logic [5:0]            bit_index_t;  // Covers the 64 bits of one buffer
    typedef logic [NUM_SLAVES-1:0] ss_t;

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT_OUT,
        SHIFT_IN,
        FINISH
    } spi_state_t;

endpackage

// ==== axi_lite_slave.sv ====
`timescale 1ns/1ps

module axi_lite_slave import spi_bus_pkg::*; (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  word_t                     s_axi_wdata,
    input  strb_t                     s_axi_wstrb,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output axi_resp_t                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output word_t                     s_axi_rdata,
    output axi_resp_t                 s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    output logic                      wr_en,
    output word_addr_t                wr_addr,
    output word_t                     wr_data,
    output strb_t                     wr_strb,
    output word_addr_t                rd_addr,
    input  word_t                     rd_data
);

    logic wr_go;
    logic rd_go;
    logic rd_en;

    // A write is taken only when address and data are both offered and B is free
    assign wr_go = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;

    // Reads yield to a write decided in the same cycle
    assign rd_go = s_axi_arvalid && !s_axi_arready && !s_axi_rvalid && !wr_go;

    assign wr_en   = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign wr_addr = s_axi_awaddr[WORD_LSB +: WORD_ADDR_BITS];
    assign wr_data = s_axi_wdata;
    assign wr_strb = s_axi_wstrb;

    assign rd_en   = s_axi_arready && s_axi_arvalid;
    assign rd_addr = s_axi_araddr[WORD_LSB +: WORD_ADDR_BITS];

    assign s_axi_wready = s_axi_awready;  // Both channels are taken on the same cycle
    assign s_axi_bresp  = OKAY;
    assign s_axi_rresp  = OKAY;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= wr_go;  // One-cycle pulse
            if (wr_en) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= rd_go;
            if (rd_en) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // Read data is captured at the address handshake and held while R stalls
    always_ff @(posedge s_axi_aclk) begin
        if (rd_en) begin
            s_axi_rdata <= rd_data;
        end
    end

endmodule

// ==== spi_reg_file.sv ====
`timescale 1ns/1ps

module spi_reg_file import spi_bus_pkg::*, spi_regs_pkg::*; (
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    input  logic       wr_en,
    input  word_addr_t wr_addr,
    input  word_t      wr_data,
    input  strb_t      wr_strb,
    input  word_addr_t rd_addr,
    output word_t      rd_data,
    output logic       cpol,
    output logic       cpha,
    output logic       start,
    output logic       read_en,
    output logic [7:0] slave_idx,
    output logic [7:0] clk_div,
    output bit_count_t tx_bits,
    output bit_count_t rx_bits,
    input  bit_index_t bit_index,
    output logic       tx_bit,
    input  logic       rx_valid,
    input  logic       rx_bit,
    input  logic       done
);

    logic [7:0] mem [MEMORY_BYTES];
    logic       ctrl_wr;
    logic       start_set;

    // Host write that hits the control byte lane
    assign ctrl_wr = wr_en && (wr_addr == word_addr_t'(CTRL_BYTE / STRB_WIDTH))
                     && wr_strb[CTRL_BYTE % STRB_WIDTH];

    // Start going from clear to set opens a new transfer
    assign start_set = ctrl_wr && !start
                       && wr_data[8 * (CTRL_BYTE % STRB_WIDTH) + CTRL_START];

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            for (int i = 0; i < MEMORY_BYTES; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (wr_strb[b]) begin
                        mem[{wr_addr, b[1:0]}] <= wr_data[8*b +: 8];
                    end
                end
            end
            // A new transfer starts with an empty receive buffer
            if (start_set) begin
                for (int i = 0; i < BUF_BYTES; i++) begin
                    mem[RX_BUF_BYTE + i] <= '0;
                end
            end
            if (rx_valid) begin
                mem[RX_BUF_BYTE + bit_index[5:3]][bit_index[2:0]] <= rx_bit;
            end
            if (done) begin
                mem[CTRL_BYTE][CTRL_START] <= 1'b0;  // Wins over a host write on this edge
            end
        end
    end

    always_comb begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
            rd_data[8*b +: 8] = mem[{rd_addr, b[1:0]}];
        end
    end

    assign cpol      = mem[CTRL_BYTE][CTRL_CPOL];
    assign cpha      = mem[CTRL_BYTE][CTRL_CPHA];
    assign start     = mem[CTRL_BYTE][CTRL_START];
    assign read_en   = mem[CTRL_BYTE][CTRL_READ];
    assign slave_idx = mem[SLAVE_BYTE];
    assign clk_div   = mem[DIV_BYTE];
    assign tx_bits   = {mem[TX_BITS_BYTE + 1], mem[TX_BITS_BYTE]};
    assign rx_bits   = {mem[RX_BITS_BYTE + 1], mem[RX_BITS_BYTE]};

    // Transmit bits go out LSB first within each byte
    assign tx_bit = mem[TX_BUF_BYTE + bit_index[5:3]][bit_index[2:0]];

endmodule

// ==== spi_engine.sv ====
`timescale 1ns/1ps

module spi_engine import spi_regs_pkg::*; (
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    input  logic       cpol,
    input  logic       cpha,
    input  logic       start,
    input  logic       read_en,
    input  logic [7:0] slave_idx,
    input  logic [7:0] clk_div,
    input  bit_count_t tx_bits,
    input  bit_count_t rx_bits,
    output bit_index_t bit_index,
    input  logic       tx_bit,
    output logic       rx_valid,
    output logic       rx_bit,
    output logic       done,
    output logic       mosi,
    input  logic       miso,
    output logic       sclk,
    output ss_t        ss_n,
    output logic       interrupt
);

    spi_state_t state;
    spi_state_t after_tx;
    logic [7:0] div_cnt;
    logic       tick;
    logic       sclk_q;
    logic       edge_phase;  // High when the next sclk edge is a sampling edge
    bit_count_t bit_cnt;
    bit_count_t phase_bits;
    logic       last_sample;

    assign tick = (state != IDLE) && (div_cnt == clk_div);

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            div_cnt <= '0;
        end else if (state == IDLE || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign after_tx    = (read_en && rx_bits != '0) ? SHIFT_IN : FINISH;
    assign phase_bits  = (state == SHIFT_IN) ? rx_bits : tx_bits;
    assign last_sample = (bit_cnt + 1'b1) == phase_bits;

    // Receive bits land in the buffer on the same edge that samples them
    assign rx_valid = tick && (state == SHIFT_IN) && edge_phase;
    assign rx_bit   = miso;
    assign done     = tick && (state == FINISH);

    // Idle clock follows cpol at once so a polarity change never shows a stray level
    assign sclk = (state == IDLE) ? cpol : sclk_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state      <= IDLE;
            sclk_q     <= 1'b0;
            ss_n       <= '1;
            mosi       <= 1'b0;
            interrupt  <= 1'b0;
            edge_phase <= 1'b0;
            bit_cnt    <= '0;
            bit_index  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= SELECT;
                        sclk_q     <= cpol;
                        interrupt  <= 1'b0;
                        edge_phase <= !cpha;  // With cpha 0 the leading edge samples
                        bit_cnt    <= '0;
                        bit_index  <= '0;
                    end
                end
                SELECT: begin
                    if (tick) begin
                        ss_n <= ~(ss_t'(1) << slave_idx);  // Out of range index selects none
                        if (tx_bits == '0) begin
                            state <= after_tx;
                        end else begin
                            state <= SHIFT_OUT;
                            if (!cpha) begin
                                mosi      <= tx_bit;
                                bit_index <= bit_index + 1'b1;
                            end
                        end
                    end
                end
                SHIFT_OUT: begin
                    if (tick) begin
                        sclk_q     <= ~sclk_q;
                        edge_phase <= ~edge_phase;
                        if (edge_phase) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_sample) begin
                                bit_cnt   <= '0;
                                bit_index <= '0;  // Receive buffer fills from bit 0
                                state     <= after_tx;
                            end
                        end else begin
                            mosi      <= tx_bit;
                            bit_index <= bit_index + 1'b1;
                        end
                    end
                end
                SHIFT_IN: begin
                    if (tick) begin
                        sclk_q     <= ~sclk_q;
                        edge_phase <= ~edge_phase;
                        if (edge_phase) begin
                            bit_cnt   <= bit_cnt + 1'b1;
                            bit_index <= bit_index + 1'b1;
                            if (last_sample) begin
                                state <= FINISH;
                            end
                        end
                    end
                end
                FINISH: begin
                    if (tick) begin
                        sclk_q    <= cpol;
                        ss_n      <= '1;
                        mosi      <= 1'b0;
                        interrupt <= 1'b1;  // Held until the next start
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== quick_spi.sv ====
`timescale 1ns/1ps

module quick_spi import spi_bus_pkg::*, spi_regs_pkg::*; (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  word_t                     s_axi_wdata,
    input  strb_t                     s_axi_wstrb,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output axi_resp_t                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output word_t                     s_axi_rdata,
    output axi_resp_t                 s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    output logic                      mosi,
    input  logic                      miso,
    output logic                      sclk,
    output ss_t                       ss_n,
    output logic                      interrupt
);

    logic       wr_en;
    word_addr_t wr_addr;
    word_t      wr_data;
    strb_t      wr_strb;
    word_addr_t rd_addr;
    word_t      rd_data;
    logic       cpol;
    logic       cpha;
    logic       start;
    logic       read_en;
    logic [7:0] slave_idx;
    logic [7:0] clk_div;
    bit_count_t tx_bits;
    bit_count_t rx_bits;
    bit_index_t bit_index;
    logic       tx_bit;
    logic       rx_valid;
    logic       rx_bit;
    logic       done;

    axi_lite_slave i_axi (.*);

    spi_reg_file i_regs (.*);

    spi_engine i_engine (.*);

endmodule

// ==== quick_spi_checker.sv ====
`timescale 1ns/1ps

module quick_spi_checker import spi_regs_pkg::*; (
    input logic       s_axi_aclk,
    input logic       s_axi_aresetn,
    input ss_t        ss_n,
    input logic       sclk,
    input logic       cpol,
    input spi_state_t engine_state,
    input logic       bvalid,
    input logic       bready,
    input logic       rvalid,
    input logic       rready,
    input logic [31:0] rdata,
    input logic       awready,
    input logic       wready
);

    // Never more than one slave selected
    a_one_select: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $onehot0(~ss_n)) else $error("more than one slave select low");

    a_idle_clock: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (&ss_n && engine_state != FINISH) |-> sclk == cpol)
        else $error("sclk left idle level while deselected");

    a_b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (bvalid && !bready) |=> bvalid) else $error("bvalid dropped before bready");

    a_r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else $error("rvalid or rdata changed before rready");

    a_aw_w: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        awready == wready) else $error("awready and wready differ");

endmodule

bind quick_spi quick_spi_checker i_checker (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .ss_n         (ss_n),
    .sclk         (sclk),
    .cpol         (cpol),
    .engine_state (i_engine.state),
    .bvalid       (s_axi_bvalid),
    .bready       (s_axi_bready),
    .rvalid       (s_axi_rvalid),
    .rready       (s_axi_rready),
    .rdata        (s_axi_rdata),
    .awready      (s_axi_awready),
    .wready       (s_axi_wready)
);

// ==== quick_spi_tb.sv ====
`timescale 1ns/1ps

module quick_spi_tb import spi_bus_pkg::*, spi_regs_pkg::*; ();

    typedef struct {
        string      name;
        logic       cpol;
        logic       cpha;
        logic [7:0] slave;
        logic [7:0] div;
        bit_count_t tx_bits;
        logic       read;
        bit_count_t rx_bits;
        logic [63:0] tx_bytes;
        logic [63:0] miso_pattern;
    } case_t;

    logic        s_axi_aclk;
    logic        s_axi_aresetn;
    logic [7:0]  s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    word_t       s_axi_wdata;
    strb_t       s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    axi_resp_t   s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [7:0]  s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    word_t       s_axi_rdata;
    axi_resp_t   s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        mosi;
    logic        miso;
    logic        sclk;
    ss_t         ss_n;
    logic        interrupt;

    case_t       cases [6];
    integer      seed;
    int          errors;
    // SPI slave model state
    logic        cur_cpol;
    logic        cur_cpha;
    int          cur_tx;
    logic [63:0] cur_pattern;
    ss_t         exp_ss;
    int          n_samples;
    logic [63:0] cap_bits;
    logic        ss_bad;
    logic        prev_sclk;
    ss_t         prev_ss;

    quick_spi i_dut (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #10 s_axi_aclk = ~s_axi_aclk;
    end

    function automatic logic [63:0] low_mask(input int n);
        if (n >= 64) return '1;
        return (64'h1 << n) - 64'h1;
    endfunction

    // Slave output for the sampling edge with the given overall index
    function automatic logic pattern_bit(input int idx);
        if (idx < cur_tx || idx - cur_tx >= 64) return 1'b0;
        return cur_pattern[idx - cur_tx];
    endfunction

    always @(sclk or ss_n) begin
        if (ss_n != prev_ss) begin
            if (prev_ss == '1) miso = pattern_bit(0);  // First bit ready before any edge
            prev_ss = ss_n;
        end
        if (sclk != prev_sclk) begin
            if (ss_n != '1) begin
                if ((sclk != cur_cpol) ^ cur_cpha) begin  // Sampling edge
                    if (n_samples < cur_tx && n_samples < 64) cap_bits[n_samples] = mosi;
                    if (ss_n !== exp_ss) ss_bad = 1'b1;
                    n_samples++;
                end else begin
                    miso = pattern_bit(n_samples);
                end
            end
            prev_sclk = sclk;
        end
    end

    task automatic give_up(input string what);
        $display("timeout waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic axi_write(input int addr, input word_t data, input strb_t strb, input int hold);
        int t;
        s_axi_awaddr  = 8'(addr);
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        t = 0;
        while (!s_axi_awready) begin
            @(negedge s_axi_aclk);
            t++;
            if (t > 50) give_up("write accept");
        end
        check_value("wready", 64'(1'b1), 64'(s_axi_wready));
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        check_value("wready pulse", 64'(1'b0), 64'(s_axi_wready));  // Ready lasts one cycle
        t = 0;
        while (!s_axi_bvalid) begin
            @(negedge s_axi_aclk);
            t++;
            if (t > 50) give_up("bvalid");
        end
        repeat (hold) begin
            @(negedge s_axi_aclk);
            check_value("bvalid held", 64'(1'b1), 64'(s_axi_bvalid));
        end
        check_value("bresp", 64'(OKAY), 64'(s_axi_bresp));
        s_axi_bready = 1'b1;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input int addr, input int hold, output word_t data);
        int t;
        s_axi_araddr  = 8'(addr);
        s_axi_arvalid = 1'b1;
        t = 0;
        while (!s_axi_arready) begin
            @(negedge s_axi_aclk);
            t++;
            if (t > 50) give_up("read accept");
        end
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        t = 0;
        while (!s_axi_rvalid) begin
            @(negedge s_axi_aclk);
            t++;
            if (t > 50) give_up("rvalid");
        end
        data = s_axi_rdata;
        repeat (hold) begin
            @(negedge s_axi_aclk);
            check_value("rvalid held", 64'(1'b1), 64'(s_axi_rvalid));
            check_value("rdata held", 64'(data), 64'(s_axi_rdata));
        end
        check_value("rresp", 64'(OKAY), 64'(s_axi_rresp));
        s_axi_rready = 1'b1;
        @(negedge s_axi_aclk);
        s_axi_rready = 1'b0;
    endtask

    task automatic run_case(input case_t c);
        logic [7:0] ctrl;
        word_t      rd;
        int         t;
        logic [63:0] rx_exp;
        ctrl = {3'b000, c.read, 2'b00, c.cpha, c.cpol};
        axi_write(TX_BUF_BYTE, c.tx_bytes[31:0], 4'hf, 0);
        axi_write(TX_BUF_BYTE + 4, c.tx_bytes[63:32], 4'hf, 0);
        axi_write(TX_BITS_BYTE, {16'h0, c.tx_bits}, 4'b0011, 0);
        axi_write(RX_BITS_BYTE, {16'h0, c.rx_bits}, 4'b0011, 0);
        axi_write(CTRL_BYTE, {8'h00, c.div, c.slave, ctrl}, 4'b0111, 0);
        check_value({c.name, " sclk idle before"}, 64'(c.cpol), 64'(sclk));
        cur_cpol    = c.cpol;
        cur_cpha    = c.cpha;
        cur_tx      = int'(c.tx_bits);
        cur_pattern = c.miso_pattern;
        exp_ss      = '1;
        exp_ss[c.slave[0]] = 1'b0;
        n_samples   = 0;
        cap_bits    = '0;
        ss_bad      = 1'b0;
        axi_write(CTRL_BYTE, {24'h0, ctrl | 8'h04}, 4'b0001, 0);
        check_value({c.name, " interrupt cleared"}, 64'(1'b0), 64'(interrupt));
        t = 0;
        while (!interrupt) begin
            @(negedge s_axi_aclk);
            t++;
            if (t > 5000) give_up("interrupt");
        end
        check_value({c.name, " samples"},
                    64'(int'(c.tx_bits) + (c.read ? int'(c.rx_bits) : 0)), 64'(n_samples));
        check_value({c.name, " tx bits"}, c.tx_bytes & low_mask(int'(c.tx_bits)),
                    cap_bits & low_mask(int'(c.tx_bits)));
        check_value({c.name, " ss during transfer"}, 64'(1'b0), 64'(ss_bad));
        check_value({c.name, " ss after"}, 64'(2'b11), 64'(ss_n));
        check_value({c.name, " sclk idle after"}, 64'(c.cpol), 64'(sclk));
        check_value({c.name, " mosi idle"}, 64'(1'b0), 64'(mosi));
        axi_read(CTRL_BYTE, 0, rd);
        check_value({c.name, " ctrl word"}, 64'({8'h00, c.div, c.slave, ctrl}), 64'(rd));
        rx_exp = c.read ? (c.miso_pattern & low_mask(int'(c.rx_bits))) : 64'h0;
        axi_read(RX_BUF_BYTE, 0, rd);
        check_value({c.name, " rx low"}, 64'(rx_exp[31:0]), 64'(rd));
        axi_read(RX_BUF_BYTE + 4, 0, rd);
        check_value({c.name, " rx high"}, 64'(rx_exp[63:32]), 64'(rd));
    endtask

    initial begin
        word_t rd;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        miso          = 1'b0;
        prev_sclk     = 1'b0;
        prev_ss       = '1;
        cur_cpol      = 1'b0;
        cur_cpha      = 1'b0;
        cur_tx        = 0;
        cur_pattern   = '0;
        exp_ss        = '1;
        n_samples     = 0;
        cap_bits      = '0;
        ss_bad        = 1'b0;
        errors        = 0;
        seed          = 79704;
        cases[0] = '{"mode0",   1'b0, 1'b0, 8'd0, 8'd0, 16'd8,  1'b0, 16'd0,  '0, '0};
        cases[1] = '{"mode1",   1'b0, 1'b1, 8'd1, 8'd1, 16'd13, 1'b1, 16'd9,  '0, '0};
        cases[2] = '{"mode2",   1'b1, 1'b0, 8'd0, 8'd2, 16'd16, 1'b1, 16'd24, '0, '0};
        cases[3] = '{"mode3",   1'b1, 1'b1, 8'd1, 8'd0, 16'd64, 1'b1, 16'd64, '0, '0};
        cases[4] = '{"rx_only", 1'b0, 1'b0, 8'd1, 8'd3, 16'd0,  1'b1, 16'd5,  '0, '0};
        cases[5] = '{"short",   1'b1, 1'b1, 8'd0, 8'd1, 16'd3,  1'b0, 16'd7,  '0, '0};
        for (int i = 0; i < 6; i++) begin
            cases[i].tx_bytes     = {$random(seed), $random(seed)};
            cases[i].miso_pattern = {$random(seed), $random(seed)};
        end
        repeat (5) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);

        // Partial strobes touch only the enabled lanes
        axi_write(TX_BUF_BYTE, 32'h11223344, 4'hf, 0);
        axi_write(TX_BUF_BYTE, 32'haabbccdd, 4'b0101, 0);
        axi_read(TX_BUF_BYTE, 0, rd);
        check_value("strobe round trip", 64'(32'h11bb33dd), 64'(rd));

        // Stalled B and R channels
        axi_write(TX_BUF_BYTE + 4, 32'h5a5aa5a5, 4'hf, 6);
        axi_read(TX_BUF_BYTE + 4, 6, rd);
        check_value("back-pressure read", 64'(32'h5a5aa5a5), 64'(rd));

        for (int i = 0; i < 6; i++) begin
            run_case(cases[i]);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
spi_bus_pkg.sv
spi_regs_pkg.sv
axi_lite_slave.sv
spi_reg_file.sv
spi_engine.sv
quick_spi.sv
quick_spi_checker.sv
quick_spi_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module quick_spi_tb -f all.f
out=$(./obj_dir/Vquick_spi_tb) || true
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
